/* src/rv_exec_pkg.sv */
package rv_exec_pkg;

    localparam int xlen = 32;

    // one-hot ALU select, bit order follows the ALU's partial results
    typedef logic [10:0] alu_op_t;

    localparam alu_op_t alu_add  = 11'b000_0000_0001;
    localparam alu_op_t alu_sltu = 11'b000_0000_0010;
    localparam alu_op_t alu_bne  = 11'b000_0000_0100;
    localparam alu_op_t alu_xor  = 11'b000_0000_1000;
    localparam alu_op_t alu_or   = 11'b000_0001_0000;
    localparam alu_op_t alu_sub  = 11'b000_0010_0000;
    localparam alu_op_t alu_sra  = 11'b000_0100_0000;
    localparam alu_op_t alu_sll  = 11'b000_1000_0000;
    localparam alu_op_t alu_and  = 11'b001_0000_0000;
    localparam alu_op_t alu_bge  = 11'b010_0000_0000;
    localparam alu_op_t alu_beq  = 11'b100_0000_0000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // branch offset is scattered over the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
    } instr_u;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_sr      = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_bge     = 3'b101;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;

endpackage

/* src/exec_if.sv */
`timescale 1ns/1ps

interface exec_if
    import rv_exec_pkg::*;
();
    logic            valid;
    alu_op_t         op;
    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm;
    logic            use_imm;
    logic [4:0]      rd;
    logic            writes_rd;
    logic            is_branch;
    logic [xlen-1:0] pc;

    modport src (output valid, op, rs1_idx, rs2_idx, rs1_val, rs2_val, imm, use_imm,
                 rd, writes_rd, is_branch, pc);
    modport dst (input valid, op, rs1_idx, rs2_idx, rs1_val, rs2_val, imm, use_imm,
                 rd, writes_rd, is_branch, pc);

endinterface

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import rv_exec_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1_idx,
    input  logic [4:0]      rs2_idx,
    output logic [xlen-1:0] rs1_val,
    output logic [xlen-1:0] rs2_val,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    function automatic logic [xlen-1:0] read_port(input logic [4:0] idx);
        logic [xlen-1:0] val;
        if (idx == 5'd0) begin
            val = '0;
        end else if (we && waddr == idx) begin
            // write-through for a same-cycle write
            val = wdata;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = read_port(rs1_idx);
        rs2_val = read_port(rs2_idx);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu
    import rv_exec_pkg::*;
(
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  alu_op_t         alu_op,
    output logic [xlen-1:0] alu_result
);

    logic do_add;
    logic do_sltu;
    logic do_bne;
    logic do_xor;
    logic do_or;
    logic do_sub;
    logic do_sra;
    logic do_sll;
    logic do_and;
    logic do_bge;
    logic do_beq;

    assign do_add  = |(alu_op & alu_add);
    assign do_sltu = |(alu_op & alu_sltu);
    assign do_bne  = |(alu_op & alu_bne);
    assign do_xor  = |(alu_op & alu_xor);
    assign do_or   = |(alu_op & alu_or);
    assign do_sub  = |(alu_op & alu_sub);
    assign do_sra  = |(alu_op & alu_sra);
    assign do_sll  = |(alu_op & alu_sll);
    assign do_and  = |(alu_op & alu_and);
    assign do_bge  = |(alu_op & alu_bge);
    assign do_beq  = |(alu_op & alu_beq);

    logic            invert_b;
    logic [xlen-1:0] adder_b;
    logic [xlen-1:0] adder_sum;
    logic            adder_cout;

    // compares and sub all become src1 + ~src2 + 1
    assign invert_b = do_sltu | do_bne | do_sub | do_bge | do_beq;
    assign adder_b  = invert_b ? ~src2 : src2;
    assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b} + {{xlen{1'b0}}, invert_b};

    logic sltu_bit;
    logic bge_bit;
    logic ne_bit;

    // no carry out means a borrow, so src1 < src2 unsigned
    assign sltu_bit = ~adder_cout;
    // differing signs decide directly, else the sign of the difference
    assign bge_bit  = ~((src1[xlen-1] != src2[xlen-1]) ? src1[xlen-1] : adder_sum[xlen-1]);
    assign ne_bit   = |adder_sum;

    logic [xlen-1:0] sra_res;
    logic [xlen-1:0] sll_res;

    assign sra_res = $signed(src1) >>> src2[4:0];
    assign sll_res = src1 << src2[4:0];

    assign alu_result = ({xlen{do_add | do_sub}} & adder_sum)
                      | ({xlen{do_sltu}} & {{(xlen - 1){1'b0}}, sltu_bit})
                      | ({xlen{do_bne}}  & {{(xlen - 1){1'b0}}, ne_bit})
                      | ({xlen{do_beq}}  & {{(xlen - 1){1'b0}}, ~ne_bit})
                      | ({xlen{do_bge}}  & {{(xlen - 1){1'b0}}, bge_bit})
                      | ({xlen{do_xor}}  & (src1 ^ src2))
                      | ({xlen{do_or}}   & (src1 | src2))
                      | ({xlen{do_and}}  & (src1 & src2))
                      | ({xlen{do_sra}}  & sra_res)
                      | ({xlen{do_sll}}  & sll_res);

    // the AND-OR mux only works with at most one select
    always_comb begin
        if (!$isunknown(alu_op)) begin
            a_op_onehot0: assert ($onehot0(alu_op))
                else $error("alu_op has more than one bit set");
        end
    end

endmodule

/* src/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
    import rv_exec_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  instr_u          instr,
    input  logic [xlen-1:0] pc,
    output logic [4:0]      rs1_idx,
    output logic [4:0]      rs2_idx,
    input  logic [xlen-1:0] rs1_val,
    input  logic [xlen-1:0] rs2_val,
    output logic            illegal,
    exec_if.src             dec
);

    alu_op_t         op_d;
    logic [xlen-1:0] imm_d;
    logic            use_imm_d;
    logic            writes_rd_d;
    logic            is_branch_d;
    logic            legal_d;
    logic            f7_base;
    logic            f7_alt;

    // register fields sit at the same place in every format
    assign rs1_idx = instr.r.rs1;
    assign rs2_idx = instr.r.rs2;

    assign f7_base = (instr.r.funct7 == funct7_base);
    assign f7_alt  = (instr.r.funct7 == funct7_alt);

    always_comb begin
        op_d        = '0;
        imm_d       = '0;
        use_imm_d   = 1'b0;
        writes_rd_d = 1'b0;
        is_branch_d = 1'b0;
        case (instr.r.opcode)
            op_reg: begin
                writes_rd_d = 1'b1;
                case (instr.r.funct3)
                    f3_add_sub: op_d = f7_alt ? alu_sub : (f7_base ? alu_add : '0);
                    f3_sll:     op_d = f7_base ? alu_sll  : '0;
                    f3_sltu:    op_d = f7_base ? alu_sltu : '0;
                    f3_xor:     op_d = f7_base ? alu_xor  : '0;
                    // only the arithmetic right shift is supported
                    f3_sr:      op_d = f7_alt  ? alu_sra  : '0;
                    f3_or:      op_d = f7_base ? alu_or   : '0;
                    f3_and:     op_d = f7_base ? alu_and  : '0;
                    default:    op_d = '0;
                endcase
            end
            op_imm: begin
                writes_rd_d = 1'b1;
                use_imm_d   = 1'b1;
                imm_d       = {{(xlen - 12){instr.i.imm[11]}}, instr.i.imm};
                case (instr.i.funct3)
                    f3_add_sub: op_d = alu_add;
                    f3_sltu:    op_d = alu_sltu;
                    f3_xor:     op_d = alu_xor;
                    f3_or:      op_d = alu_or;
                    f3_and:     op_d = alu_and;
                    // shift immediates reuse the funct7 slot
                    f3_sll:     op_d = f7_base ? alu_sll : '0;
                    f3_sr:      op_d = f7_alt  ? alu_sra : '0;
                    default:    op_d = '0;
                endcase
            end
            op_branch: begin
                is_branch_d = 1'b1;
                imm_d = {{(xlen - 13){instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                         instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
                case (instr.b.funct3)
                    f3_beq:  op_d = alu_beq;
                    f3_bne:  op_d = alu_bne;
                    f3_bge:  op_d = alu_bge;
                    default: op_d = '0;
                endcase
            end
            default: op_d = '0;
        endcase
    end

    // anything without an ALU operation is unsupported
    assign legal_d = |op_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            dec.valid <= instr_valid & legal_d;
            illegal   <= instr_valid & ~legal_d;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec.op        <= op_d;
            dec.rs1_idx   <= instr.r.rs1;
            dec.rs2_idx   <= instr.r.rs2;
            dec.rs1_val   <= rs1_val;
            dec.rs2_val   <= rs2_val;
            dec.imm       <= imm_d;
            dec.use_imm   <= use_imm_d;
            dec.rd        <= instr.r.rd;
            dec.writes_rd <= writes_rd_d;
            dec.is_branch <= is_branch_d;
            dec.pc        <= pc;
        end
    end

    a_dec_op_onehot: assert property (@(posedge clk) disable iff (rst)
        dec.valid |-> $onehot(dec.op))
        else $error("decoded op not one-hot");

endmodule

/* src/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage
    import rv_exec_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    exec_if.dst             dec,
    output logic            we,
    output logic [4:0]      waddr,
    output logic [xlen-1:0] wdata,
    output logic            wb_valid,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data,
    output logic            br_valid,
    output logic            br_taken,
    output logic [xlen-1:0] br_target
);

    logic            fwd1;
    logic            fwd2;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] target;

    // previous instruction's result has not reached the register file yet
    assign fwd1 = wb_valid && wb_rd != 5'd0 && wb_rd == dec.rs1_idx;
    assign fwd2 = wb_valid && wb_rd != 5'd0 && wb_rd == dec.rs2_idx;

    assign op1  = fwd1 ? wb_data : dec.rs1_val;
    assign op2  = fwd2 ? wb_data : dec.rs2_val;
    assign src2 = dec.use_imm ? dec.imm : op2;

    assign target = dec.pc + dec.imm;

    alu alu_i (
        .src1       (op1),
        .src2       (src2),
        .alu_op     (dec.op),
        .alu_result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            br_valid <= 1'b0;
        end else begin
            wb_valid <= dec.valid & dec.writes_rd;
            br_valid <= dec.valid & dec.is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            wb_rd     <= dec.rd;
            wb_data   <= alu_result;
            // compare ops leave the outcome in bit 0
            br_taken  <= alu_result[0];
            br_target <= target;
        end
    end

    // shown result is written to the register file at the end of its cycle
    assign we    = wb_valid;
    assign waddr = wb_rd;
    assign wdata = wb_data;

    a_wb_br_excl: assert property (@(posedge clk) disable iff (rst)
        !(wb_valid && br_valid))
        else $error("write-back and branch report in the same cycle");

endmodule

/* src/exec_core.sv */
`timescale 1ns/1ps

module exec_core
    import rv_exec_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    output logic            wb_valid,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data,
    output logic            br_valid,
    output logic            br_taken,
    output logic [xlen-1:0] br_target,
    output logic            illegal
);

    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_wdata;

    exec_if dec_bus ();

    instr_decoder instr_decoder_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .illegal     (illegal),
        .dec         (dec_bus.src)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .rst     (rst),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    exec_stage exec_stage_i (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec_bus.dst),
        .we        (rf_we),
        .waddr     (rf_waddr),
        .wdata     (rf_wdata),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .br_valid  (br_valid),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

/* sim/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// architectural registers and the outcomes still to be seen
logic [31:0] arch_regs [0:31];
int          wb_due_q [$];
logic [4:0]  wb_rd_q [$];
logic [31:0] wb_data_q [$];
int          br_due_q [$];
logic        br_taken_q [$];
logic [31:0] br_target_q [$];
int          ill_due_q [$];

task automatic clear_model();
    for (int i = 0; i < 32; i++) begin
        arch_regs[i] = '0;
    end
endtask

// runs one word in program order, due is the cycle its result shows up
task automatic exec_ref(input logic [31:0] word, input logic [31:0] pc_v, input int due);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic        ok;
    logic        is_br;
    f7    = word[31:25];
    f3    = word[14:12];
    rd    = word[11:7];
    a     = arch_regs[word[19:15]];
    b     = arch_regs[word[24:20]];
    imm   = {{20{word[31]}}, word[31:20]};
    res   = '0;
    ok    = 1'b1;
    is_br = 1'b0;
    case (word[6:0])
        7'b0110011: begin
            case ({f7, f3})
                10'h000: res = a + b;
                10'h100: res = a - b;
                10'h003: res = {31'd0, a < b};
                10'h004: res = a ^ b;
                10'h006: res = a | b;
                10'h007: res = a & b;
                10'h001: res = a << b[4:0];
                10'h105: res = $signed(a) >>> b[4:0];
                default: ok = 1'b0;
            endcase
        end
        7'b0010011: begin
            case (f3)
                3'b000:  res = a + imm;
                3'b011:  res = {31'd0, a < imm};
                3'b100:  res = a ^ imm;
                3'b110:  res = a | imm;
                3'b111:  res = a & imm;
                3'b001:  res = a << word[24:20];
                3'b101:  res = $signed(a) >>> word[24:20];
                default: ok = 1'b0;
            endcase
            // shift immediates carry a fixed upper field
            if (f3 == 3'b001 && f7 != 7'h00) begin
                ok = 1'b0;
            end
            if (f3 == 3'b101 && f7 != 7'h20) begin
                ok = 1'b0;
            end
        end
        7'b1100011: begin
            is_br = 1'b1;
            imm   = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
            case (f3)
                3'b000:  res = {31'd0, a == b};
                3'b001:  res = {31'd0, a != b};
                3'b101:  res = {31'd0, $signed(a) >= $signed(b)};
                default: ok = 1'b0;
            endcase
        end
        default: ok = 1'b0;
    endcase
    if (!ok) begin
        // illegal is flagged one cycle ahead of a result
        ill_due_q.push_back(due - 1);
    end else if (is_br) begin
        br_due_q.push_back(due);
        br_taken_q.push_back(res[0]);
        br_target_q.push_back(pc_v + imm);
    end else begin
        wb_due_q.push_back(due);
        wb_rd_q.push_back(rd);
        wb_data_q.push_back(res);
        if (rd != 5'd0) begin
            arch_regs[rd] = res;
        end
    end
endtask

`endif

/* sim/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb;

    localparam int n_directed  = 16;
    localparam int n_random    = 400;
    // one strobe per cycle plus at most one gap each, reset and drain fit in the rest
    localparam int cycle_limit = (n_directed + n_random) * 2 + 50;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        br_valid;
    logic        br_taken;
    logic [31:0] br_target;
    logic        illegal;

    int          seed   = 32'h28b0_31f2;
    int          cycle  = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] next_pc;
    logic [31:0] gap;
    logic        wb_hit;
    logic        br_hit;
    logic        ill_hit;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        exp_taken;
    logic [31:0] exp_target;

    `include "exec_model.svh"

    exec_core exec_core_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .illegal     (illegal)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("run stopped after %0d cycles with results still pending", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cycle);
        end
    endtask

    task automatic report_strobe(input string name, input logic seen);
        errors++;
        if (seen === 1'b1) begin
            $display("unexpected %s strobe at cycle %0d", name, cycle);
        end else begin
            $display("expected %s strobe did not appear at cycle %0d", name, cycle);
        end
    endtask

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [2:0] f3,
                                                input logic [4:0] rd, rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [2:0] f3,
                                                input logic [4:0] rs1, rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // mostly x0..x7 so that results feed later reads
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[3:0] == 4'd0) ? r[8:4] : {2'b00, r[6:4]};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [4:0]  shamt;
        r     = $random(seed);
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = (r[7:5] == 3'd0) ? rs1 : pick_reg();
        shamt = (r[17:16] == 2'd0) ? 5'd0 : (r[17:16] == 2'd1) ? 5'd31 : r[24:20];
        if (r[14:12] <= 3'd2) begin
            case (r[10:8])
                3'd0:    return r_type_word(7'h00, 3'b000, rd, rs1, rs2);
                3'd1:    return r_type_word(7'h20, 3'b000, rd, rs1, rs2);
                3'd2:    return r_type_word(7'h00, 3'b011, rd, rs1, rs2);
                3'd3:    return r_type_word(7'h00, 3'b100, rd, rs1, rs2);
                3'd4:    return r_type_word(7'h00, 3'b110, rd, rs1, rs2);
                3'd5:    return r_type_word(7'h00, 3'b111, rd, rs1, rs2);
                3'd6:    return r_type_word(7'h00, 3'b001, rd, rs1, rs2);
                default: return r_type_word(7'h20, 3'b101, rd, rs1, rs2);
            endcase
        end else if (r[14:12] <= 3'd5) begin
            // slti is not supported, sltiu takes its slot
            f3 = (r[10:8] == 3'b010) ? 3'b011 : r[10:8];
            if (f3 == 3'b001) begin
                return i_type_word({7'h00, shamt}, f3, rd, rs1);
            end else if (f3 == 3'b101) begin
                return i_type_word({7'h20, shamt}, f3, rd, rs1);
            end
            return i_type_word(r[27:16], f3, rd, rs1);
        end else if (r[14:12] == 3'd6 || r[18]) begin
            f3 = (r[9:8] == 2'd0) ? 3'b000 : (r[9:8] == 2'd1) ? 3'b001 : 3'b101;
            return branch_word({r[28:17], 1'b0}, f3, rs1, rs2);
        end else if (r[15]) begin
            // load opcode
            return {r[31:7], 7'b0000011};
        end
        // slt, not part of the subset
        return r_type_word(7'h00, 3'b010, rd, rs1, rs2);
    endfunction

    // the strobe is sampled on the next edge, its result two edges later
    task automatic send_instr(input logic [31:0] word);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        pc          <= next_pc;
        exec_ref(word, next_pc, cycle + 3);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            wb_hit  = wb_due_q.size() > 0 && wb_due_q[0] == cycle;
            br_hit  = br_due_q.size() > 0 && br_due_q[0] == cycle;
            ill_hit = ill_due_q.size() > 0 && ill_due_q[0] == cycle;
            if (wb_valid !== wb_hit) begin
                report_strobe("write-back", wb_valid);
            end
            if (br_valid !== br_hit) begin
                report_strobe("branch", br_valid);
            end
            if (illegal !== ill_hit) begin
                report_strobe("illegal", illegal);
            end
            if (wb_hit) begin
                wb_due_q.delete(0);
                exp_rd   = wb_rd_q.pop_front();
                exp_data = wb_data_q.pop_front();
                if (wb_valid === 1'b1) begin
                    check_val("wb_rd", {27'd0, wb_rd}, {27'd0, exp_rd});
                    check_val("wb_data", wb_data, exp_data);
                end
            end
            if (br_hit) begin
                br_due_q.delete(0);
                exp_taken  = br_taken_q.pop_front();
                exp_target = br_target_q.pop_front();
                if (br_valid === 1'b1) begin
                    check_val("br_taken", {31'd0, br_taken}, {31'd0, exp_taken});
                    check_val("br_target", br_target, exp_target);
                end
            end
            if (ill_hit) begin
                ill_due_q.delete(0);
            end
        end
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        next_pc     = 32'h0000_1000;
        clear_model();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // quiet cycles right after reset
        repeat (4) idle_cycle();
        send_instr(i_type_word(12'd31, 3'b000, 5'd1, 5'd0));
        send_instr(i_type_word(12'hfff, 3'b000, 5'd2, 5'd0));
        send_instr(i_type_word(12'h800, 3'b000, 5'd3, 5'd0));
        send_instr(r_type_word(7'h00, 3'b001, 5'd4, 5'd2, 5'd1));
        send_instr(r_type_word(7'h20, 3'b101, 5'd5, 5'd4, 5'd1));
        send_instr(r_type_word(7'h00, 3'b001, 5'd6, 5'd2, 5'd0));
        send_instr(r_type_word(7'h20, 3'b101, 5'd7, 5'd4, 5'd0));
        send_instr(r_type_word(7'h00, 3'b011, 5'd6, 5'd2, 5'd2));
        send_instr(r_type_word(7'h20, 3'b000, 5'd7, 5'd0, 5'd2));
        send_instr(r_type_word(7'h00, 3'b011, 5'd6, 5'd0, 5'd2));
        // x0 written, then read back right away
        send_instr(i_type_word(12'd5, 3'b000, 5'd0, 5'd2));
        send_instr(r_type_word(7'h00, 3'b000, 5'd7, 5'd0, 5'd0));
        send_instr(branch_word(13'd8, 3'b000, 5'd2, 5'd2));
        send_instr(branch_word(-13'sd16, 3'b001, 5'd2, 5'd2));
        send_instr(branch_word(13'd4, 3'b101, 5'd3, 5'd1));
        send_instr(branch_word(13'h1000, 3'b101, 5'd1, 5'd3));
        for (int n = 0; n < n_random; n++) begin
            gap = $random(seed);
            if (gap[1:0] == 2'd0) begin
                idle_cycle();
            end
            send_instr(random_instr());
        end
        idle_cycle();
        while (wb_due_q.size() + br_due_q.size() + ill_due_q.size() != 0) begin
            @(posedge clk);
        end
        // nothing more may come out
        repeat (3) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+sim
src/rv_exec_pkg.sv
src/exec_if.sv
src/reg_file.sv
src/alu.sv
src/instr_decoder.sv
src/exec_stage.sv
src/exec_core.sv
sim/exec_core_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert -Wno-fatal --top-module exec_core_tb \
        -f sources.f -o exec_core_sim && ./obj_dir/exec_core_sim) || {
    echo "$out"
    exit 1
}
echo "$out"
echo "$out" | grep -qx "all tests passed" || exit 1
